/* source/fetch_pkg.sv */
package fetch_pkg;

	// byte addressed fetch space with four lines of four words each.
	localparam int addr_len       = 32;
	localparam int offset_len     = 4;
	localparam int index_len      = 2;
	localparam int tag_len        = addr_len - offset_len - index_len;
	localparam int words_per_line = 4;
	localparam int line_count     = 4;

	// split of the line offset into a word select and a byte select.
	localparam int word_len = $clog2(words_per_line);
	localparam int byte_len = offset_len - word_len;

	// every instruction is one word wide.
	localparam int inst_bytes = 4;

	localparam logic [word_len-1:0] last_word = word_len'(words_per_line - 1);

	typedef struct packed {
		logic [tag_len-1:0]   tag;
		logic [index_len-1:0] index;
		logic [word_len-1:0]  word;
		logic [byte_len-1:0]  byte_offset;
	} fetch_addr_t;

	// refill walks these in order and returns to idle after commit.
	typedef enum logic [1:0] {
		idle,
		request,
		collect,
		commit
	} refill_state_t;

endpackage

/* source/bus_pkg.sv */
package bus_pkg;
	import fetch_pkg::*;

	localparam int data_len = 32;

	// read request towards memory, one word per transfer.
	typedef struct packed {
		logic [addr_len-1:0] addr;
	} mem_req_t;

	typedef struct packed {
		logic [data_len-1:0] data;
	} mem_resp_t;

	typedef struct packed {
		logic [addr_len-1:0] pc;
	} fetch_req_t;

	typedef struct packed {
		logic [addr_len-1:0] pc;
		logic [data_len-1:0] data;
	} fetch_inst_t;

	// one word written into the cache arrays by refill.
	typedef struct packed {
		fetch_addr_t         addr;
		logic [data_len-1:0] data;
	} fill_write_t;

endpackage

/* source/fetch_sequencer.sv */
`timescale 1ns/1ps

module fetch_sequencer
	import fetch_pkg::*;
	import bus_pkg::*;
(
	input  logic                clock,
	input  logic                arst_n,
	input  logic                redirect,
	input  logic [addr_len-1:0] redirect_pc,
	output fetch_req_t          req,
	output logic                req_valid,
	input  logic                req_ready
);

	logic        busy;
	logic        req_fire;
	fetch_addr_t pc;

	assign req_fire = req_valid && req_ready;

	// the sequencer stays silent until the first redirect gives it a start point.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
		end else if (redirect) begin
			busy <= 1'b1;
		end
	end

	// a redirect wins over the normal advance, so an unaccepted request is dropped.
	always_ff @(posedge clock) begin
		if (redirect) begin
			pc <= fetch_addr_t'(redirect_pc);
		end else if (req_fire) begin
			pc <= fetch_addr_t'(pc + addr_len'(inst_bytes));
		end
	end

	// once running, a request is offered every cycle.
	assign req_valid = busy;
	assign req.pc    = pc;

endmodule

/* source/icache_lookup.sv */
`timescale 1ns/1ps

module icache_lookup
	import fetch_pkg::*;
	import bus_pkg::*;
(
	input  logic        clock,
	input  logic        arst_n,
	input  logic        redirect,
	input  logic        fence,
	input  fetch_req_t  req,
	input  logic        req_valid,
	output logic        req_ready,
	output fetch_inst_t inst,
	output logic        inst_valid,
	input  logic        inst_ready,
	output logic        miss_valid,
	output fetch_addr_t miss_addr,
	input  fill_write_t fill,
	input  logic        fill_valid,
	input  logic        fill_done
);

	logic [data_len-1:0]   data_array [line_count][words_per_line];
	logic [tag_len-1:0]    tag_array [line_count];
	logic [line_count-1:0] line_valid;

	logic        hold_valid;
	fetch_addr_t hold_addr;

	logic line_hit;
	logic hit;
	logic need_fill;
	logic out_free;
	logic retire;
	logic req_fire;

	// the held request is tested against the indexed line in the cycle after it is taken.
	assign line_hit = line_valid[hold_addr.index] &&
		(tag_array[hold_addr.index] == hold_addr.tag);

	// while a miss is open the test is suspended until fill_done.
	assign hit       = hold_valid && !miss_valid && line_hit;
	assign need_fill = hold_valid && !miss_valid && !line_hit;

	assign out_free  = !inst_valid || inst_ready;
	assign retire    = hit && out_free;
	assign req_ready = out_free && (!hold_valid || retire);
	assign req_fire  = req_valid && req_ready;
	assign miss_addr = hold_addr;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			hold_valid <= 1'b0;
		end else if (redirect) begin
			hold_valid <= 1'b0;
		end else if (req_fire) begin
			hold_valid <= 1'b1;
		end else if (retire) begin
			hold_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (req_fire) begin
			hold_addr <= fetch_addr_t'(req.pc);
		end
	end

	// the miss level drops on fill_done and the held request is tested again.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			miss_valid <= 1'b0;
		end else if (redirect || fill_done) begin
			miss_valid <= 1'b0;
		end else if (need_fill) begin
			miss_valid <= 1'b1;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			inst_valid <= 1'b0;
		end else if (redirect) begin
			inst_valid <= 1'b0;
		end else if (retire) begin
			inst_valid <= 1'b1;
		end else if (inst_ready) begin
			inst_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (retire) begin
			inst.pc   <= hold_addr;
			inst.data <= data_array[hold_addr.index][hold_addr.word];
		end
	end

	// a line being refilled is invalid until commit, so its old tag cannot hit on new data.
	// commit comes last and so wins over a fence in the same cycle.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			line_valid <= '0;
		end else begin
			if (fence) begin
				line_valid <= '0;
			end
			if (fill_valid) begin
				line_valid[fill.addr.index] <= 1'b0;
			end
			if (fill_done) begin
				line_valid[fill.addr.index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data_array[fill.addr.index][fill.addr.word] <= fill.data;
		end
		if (fill_done) begin
			tag_array[fill.addr.index] <= fill.addr.tag;
		end
	end

endmodule

/* source/line_refill.sv */
`timescale 1ns/1ps

module line_refill
	import fetch_pkg::*;
	import bus_pkg::*;
(
	input  logic        clock,
	input  logic        arst_n,
	input  logic        miss_valid,
	input  fetch_addr_t miss_addr,
	output mem_req_t    mem_req,
	output logic        mem_req_valid,
	input  logic        mem_req_ready,
	input  mem_resp_t   mem_resp,
	input  logic        mem_resp_valid,
	output fill_write_t fill,
	output logic        fill_valid,
	output logic        fill_done
);

	refill_state_t state;

	logic [tag_len-1:0]   line_tag;
	logic [index_len-1:0] line_index;
	logic [word_len-1:0]  issue_count;
	logic [word_len-1:0]  return_count;
	logic [word_len-1:0]  fill_word;
	logic [data_len-1:0]  fill_data;

	logic start;
	logic issue_fire;
	logic busy;

	assign start      = (state == idle) && miss_valid;
	assign issue_fire = mem_req_valid && mem_req_ready;
	assign busy       = (state == request) || (state == collect);

	// issue and return are counted apart, so all four reads may be in flight at once.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state       <= idle;
			issue_count <= '0;
		end else begin
			case (state)
				idle: begin
					if (miss_valid) begin
						issue_count <= '0;
						state       <= request;
					end
				end
				request: begin
					if (issue_fire) begin
						issue_count <= issue_count + 1'b1;
						if (issue_count == last_word) begin
							state <= collect;
						end
					end
				end
				collect: begin
					if (fill_valid && fill_word == last_word) begin
						state <= commit;
					end
				end
				commit: begin
					state <= idle;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			return_count <= '0;
			fill_valid   <= 1'b0;
		end else begin
			fill_valid <= mem_resp_valid && busy;
			if (state == idle) begin
				return_count <= '0;
			end else if (mem_resp_valid) begin
				return_count <= return_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			line_tag   <= miss_addr.tag;
			line_index <= miss_addr.index;
		end
		if (mem_resp_valid) begin
			fill_word <= return_count;
			fill_data <= mem_resp.data;
		end
	end

	// reads start at the first word of the line and go up in order.
	assign mem_req_valid = (state == request);
	assign mem_req.addr  = {line_tag, line_index, issue_count, {byte_len{1'b0}}};

	assign fill.addr.tag         = line_tag;
	assign fill.addr.index       = line_index;
	assign fill.addr.word        = fill_word;
	assign fill.addr.byte_offset = '0;
	assign fill.data             = fill_data;
	assign fill_done             = (state == commit);

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
	import fetch_pkg::*;
	import bus_pkg::*;
(
	input  logic                clock,
	input  logic                arst_n,
	input  logic                redirect,
	input  logic [addr_len-1:0] redirect_pc,
	input  logic                fence,
	output fetch_inst_t         inst,
	output logic                inst_valid,
	input  logic                inst_ready,
	output mem_req_t            mem_req,
	output logic                mem_req_valid,
	input  logic                mem_req_ready,
	input  mem_resp_t           mem_resp,
	input  logic                mem_resp_valid
);

	fetch_req_t  req;
	logic        req_valid;
	logic        req_ready;
	logic        miss_valid;
	fetch_addr_t miss_addr;
	fill_write_t fill;
	logic        fill_valid;
	logic        fill_done;

	fetch_sequencer sequencer (
		.clock(clock), .arst_n(arst_n),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.req(req), .req_valid(req_valid), .req_ready(req_ready)
	);

	icache_lookup lookup (
		.clock(clock), .arst_n(arst_n),
		.redirect(redirect), .fence(fence),
		.req(req), .req_valid(req_valid), .req_ready(req_ready),
		.inst(inst), .inst_valid(inst_valid), .inst_ready(inst_ready),
		.miss_valid(miss_valid), .miss_addr(miss_addr),
		.fill(fill), .fill_valid(fill_valid), .fill_done(fill_done)
	);

	line_refill refill (
		.clock(clock), .arst_n(arst_n),
		.miss_valid(miss_valid), .miss_addr(miss_addr),
		.mem_req(mem_req), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready),
		.mem_resp(mem_resp), .mem_resp_valid(mem_resp_valid),
		.fill(fill), .fill_valid(fill_valid), .fill_done(fill_done)
	);

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clock,
	output logic arst_n
);

	initial begin
		clock  = 1'b0;
		arst_n = 1'b0;
		forever #4 clock = ~clock;
	end

	// reset is released shortly after the second rising edge.
	initial begin
		repeat (2) @(posedge clock);
		#1 arst_n = 1'b1;
	end

endmodule

/* bench/fetch_unit_assertions.sv */
`timescale 1ns/1ps

module fetch_unit_assertions
	import fetch_pkg::*;
	import bus_pkg::*;
(
	input logic        clock,
	input logic        arst_n,
	input logic        redirect,
	input fetch_inst_t inst,
	input logic        inst_valid,
	input logic        inst_ready,
	input mem_req_t    mem_req,
	input logic        mem_req_valid,
	input logic        mem_req_ready
);

	int   failure_count = 0;
	logic started;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			started <= 1'b0;
		end else if (redirect) begin
			started <= 1'b1;
		end
	end

	// nothing may leave the unit before the first redirect.
	quiet_before_start: assert property (@(posedge clock) disable iff (!arst_n)
		!started |-> (!inst_valid && !mem_req_valid))
		else begin
			$error("output activity before the first redirect");
			failure_count++;
		end

	data_matches_pc: assert property (@(posedge clock) disable iff (!arst_n)
		(inst_valid && inst_ready) |-> (inst.data == (inst.pc ^ 32'h5a5a_0000)))
		else begin
			$error("instruction data does not match its pc");
			failure_count++;
		end

	inst_held_when_stalled: assert property (@(posedge clock) disable iff (!arst_n)
		(inst_valid && !inst_ready && !redirect) |=> (inst_valid && $stable(inst)))
		else begin
			$error("inst changed while stalled");
			failure_count++;
		end

	// reads stay stable until memory takes them.
	mem_req_held: assert property (@(posedge clock) disable iff (!arst_n)
		(mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
		else begin
			$error("memory request changed before it was accepted");
			failure_count++;
		end

endmodule

/* bench/fetch_unit_tb.sv */
`timescale 1ns/1ps

module fetch_unit_tb
	import fetch_pkg::*;
	import bus_pkg::*;
;

	localparam logic [31:0] data_mask = 32'h5a5a_0000;
	localparam int wait_limit = 200;

	logic clock, arst_n, redirect, fence, inst_ready, mem_req_ready, mem_resp_valid;
	logic [31:0] redirect_pc;
	fetch_inst_t inst;
	logic inst_valid, mem_req_valid;
	mem_req_t mem_req;
	mem_resp_t mem_resp;

	logic [31:0] lfsr = 32'h09c7_b595;
	logic [31:0] expected_pc = '0;
	logic [31:0] resp_addr [$];
	int resp_due [$];
	int cycle = 0;
	int errors = 0;
	int transfers = 0;
	int reads = 0;
	logic timed_out = 1'b0;

	tb_clock clocks (.clock(clock), .arst_n(arst_n));

	fetch_unit UUT (.*);

	bind fetch_unit fetch_unit_assertions checks (
		.clock(clock), .arst_n(arst_n), .redirect(redirect),
		.inst(inst), .inst_valid(inst_valid), .inst_ready(inst_ready),
		.mem_req(mem_req), .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready)
	);

	// galois lfsr, one step per bit taken.
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return value;
	endfunction

	// memory answers in order, one to four cycles after a read is taken.
	initial begin
		mem_req_ready  = 1'b0;
		mem_resp_valid = 1'b0;
		mem_resp       = '0;
		forever begin
			@(posedge clock);
			#1;
			cycle++;
			if (resp_due.size() > 0 && resp_due[0] <= cycle) begin
				mem_resp_valid = 1'b1;
				mem_resp.data  = resp_addr.pop_front() ^ data_mask;
				void'(resp_due.pop_front());
			end else begin
				mem_resp_valid = 1'b0;
			end
			mem_req_ready = (random_bits(2) != 0);
		end
	end

	// transfers are seen half a cycle before the edge that takes them.
	always @(negedge clock) begin
		if (mem_req_valid && mem_req_ready) begin
			reads++;
			resp_addr.push_back(mem_req.addr);
			resp_due.push_back(cycle + 2 + int'(random_bits(2)));
		end
		if (inst_valid && inst_ready) begin
			if (inst.pc !== expected_pc) begin
				$display("FAIL %0t: pc %h, expected %h", $time, inst.pc, expected_pc);
				errors++;
			end
			if (inst.data !== (expected_pc ^ data_mask)) begin
				$display("FAIL %0t: data %h for pc %h", $time, inst.data, expected_pc);
				errors++;
			end
			expected_pc = expected_pc + 32'd4;
			transfers++;
		end
		if (redirect) begin
			expected_pc = redirect_pc;
		end
	end

	task automatic finish_run();
		$display("errors: %0d bench, %0d assertion", errors, UUT.checks.failure_count);
		if (errors == 0 && UUT.checks.failure_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	endtask

	task automatic issue_redirect(input logic [31:0] pc, input logic with_fence);
		redirect    = 1'b1;
		redirect_pc = pc;
		fence       = with_fence;
		inst_ready  = 1'b1;
		@(posedge clock);
		#1;
		redirect = 1'b0;
		fence    = 1'b0;
	endtask

	// the next redirect goes out while the last word is shown, so no prefetch miss starts.
	task automatic run_pass(input int count, input logic [31:0] next_pc, input logic with_fence);
		int   first = transfers;
		int   seen  = transfers;
		int   idle  = 0;
		logic ready_draw;
		while (!timed_out && !(transfers - first == count - 1 && inst_valid)) begin
			@(posedge clock);
			ready_draw = (random_bits(2) != 0);
			#1;
			inst_ready = ready_draw;
			idle = (transfers != seen) ? 0 : idle + 1;
			seen = transfers;
			if (idle > wait_limit) begin
				$display("timeout: no instruction for %0d cycles", wait_limit);
				errors++;
				timed_out = 1'b1;
			end
		end
		if (!timed_out) begin
			issue_redirect(next_pc, with_fence);
		end
	endtask

	initial begin
		int idle = 0;
		int reads_before;
		redirect = 1'b0;
		redirect_pc = '0;
		fence = 1'b0;
		inst_ready = 1'b0;
		while (arst_n !== 1'b1 && !timed_out) begin
			@(posedge clock);
			#1;
			idle++;
			if (idle > wait_limit) begin
				$display("timeout: reset was never released");
				errors++;
				timed_out = 1'b1;
			end
		end
		repeat (5) @(posedge clock);
		#1;
		issue_redirect(32'h0000_1000, 1'b0);
		run_pass(16, 32'h0000_1000, 1'b0);
		reads_before = reads;
		run_pass(16, 32'h0000_1000, 1'b1);
		if (!timed_out && reads != reads_before) begin
			$display("FAIL %0t: %0d reads on a cached loop", $time, reads - reads_before);
			errors++;
		end
		reads_before = reads;
		run_pass(16, 32'h0000_3008, 1'b0);
		if (!timed_out && reads - reads_before != 16) begin
			$display("FAIL %0t: %0d reads after fence, expected 16", $time, reads - reads_before);
			errors++;
		end
		run_pass(24, 32'h0000_0100, 1'b0);
		repeat (4) @(posedge clock);
		finish_run();
	end

endmodule

/* list.f */
source/fetch_pkg.sv
source/bus_pkg.sv
source/fetch_sequencer.sv
source/icache_lookup.sv
source/line_refill.sv
source/fetch_unit.sv
bench/tb_clock.sv
bench/fetch_unit_assertions.sv
bench/fetch_unit_tb.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
TOP        ?= fetch_unit_tb
FILE_LIST  ?= list.f
RUN_FLAGS  ?= +verilator+error+limit+1000
OBJ_DIR    ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
